/* filelist.f */
source/dma_read_pkg.sv
source/dma_csr_regs.sv
source/dma_fetch_sequencer.sv
source/dma_read_fifo.sv
source/dma_read_controller.sv
tests/tb_clock_gen.sv
tests/dma_read_controller_assertions.sv
tests/dma_read_controller_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA read controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module dma_read_controller_tb \
	-f filelist.f -o dma_read_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/dma_read_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi
exit 0

/* tests/dma_read_controller_tb.sv */
`timescale 1ns/1ps

module dma_read_controller_tb import dma_read_pkg::*; ();

	// Longest run is a few thousand cycles
	localparam int TIMEOUT_CYCLES = 20000;

	logic                         target_clk;
	logic                         target_rst_b;
	logic                         csr_valid;
	logic                         csr_r_nw;
	logic [ID_W-1:0]              csr_did;
	logic [CSR_ADDR_W-1:0]        csr_addr;
	csr_word_u                    csr_wdata;
	logic                         csr_ack;
	logic [CSR_DATA_W-1:0]        csr_rdata;
	logic                         fabric_req_valid;
	logic [ADDR_W-1:0]            fabric_req_addr;
	logic [$clog2(BURST_BEATS):0] fabric_req_len;
	logic [ID_W-1:0]              fabric_req_did;
	logic [ID_W-1:0]              fabric_req_subdid;
	logic                         fabric_credit = 1'b0;
	logic                         fabric_rsp_valid = 1'b0;
	logic [ID_W-1:0]              fabric_rsp_did = '0;
	logic [ID_W-1:0]              fabric_rsp_subdid = '0;
	logic [DATA_W-1:0]            fabric_rsp_data = '0;
	logic                         user_request = 1'b0;
	logic [DATA_W-1:0]            user_data;
	logic                         user_data_ready;
	logic                         fifo_empty;

	logic [31:0]       lfsr_state = 32'hdd65;
	string             test_name = "reset";
	logic              drain_on = 1'b0;
	logic              foreign_on = 1'b0;
	logic              hold_credits = 1'b0;
	logic [DATA_W-1:0] beat_q[$];
	logic [DATA_W-1:0] word_q[$];
	logic [ADDR_W-1:0] req_addr_q[$];
	int                beats_sent = 0;
	int                credits_owed = 0;
	int                credit_wait = 0;
	int                req_count = 0;
	int                words_seen = 0;
	int                cycles = 0;

	tb_clock_gen i_tb_clock_gen (
		.target_clk   (target_clk),
		.target_rst_b (target_rst_b)
	);

	dma_read_controller i_dma_read_controller (.*);

	bind dma_read_controller dma_read_controller_assertions i_dma_read_controller_assertions (
		.target_clk        (target_clk),
		.target_rst_b      (target_rst_b),
		.fabric_req_valid  (fabric_req_valid),
		.fabric_req_len    (fabric_req_len),
		.fabric_req_did    (fabric_req_did),
		.fabric_req_subdid (fabric_req_subdid),
		.fabric_credit     (fabric_credit),
		.fabric_rsp_valid  (fabric_rsp_valid),
		.fabric_rsp_did    (fabric_rsp_did),
		.fabric_rsp_subdid (fabric_rsp_subdid),
		.user_request      (user_request),
		.fifo_empty        (fifo_empty),
		.user_data_ready   (user_data_ready)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(rand_bit());
		return v;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
		assert (actual == expected)
		else stop_with_error($sformatf("Mismatch %s expected %h actual %h",
			test_name, expected, actual));
	endtask

	// One host access; the ack is due one cycle after the strobe
	task automatic csr_access(input logic r_nw, input logic [ID_W-1:0] did,
		input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] wdata,
		output logic acked, output logic [CSR_DATA_W-1:0] rdata);
		@(posedge target_clk);
		csr_valid       <= 1'b1;
		csr_r_nw        <= r_nw;
		csr_did         <= did;
		csr_addr        <= addr;
		csr_wdata.value <= wdata;
		@(posedge target_clk);
		csr_valid <= 1'b0;
		@(posedge target_clk);
		acked = csr_ack;
		rdata = csr_rdata;
	endtask

	task automatic write_reg(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] data);
		logic                  acked;
		logic [CSR_DATA_W-1:0] rdata;
		csr_access(1'b0, CSR_DID, addr, data, acked, rdata);
		assert (acked) else stop_with_error($sformatf("Register write to %h got no ack", addr));
	endtask

	task automatic read_reg(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] expected);
		logic                  acked;
		logic [CSR_DATA_W-1:0] rdata;
		csr_access(1'b1, CSR_DID, addr, '0, acked, rdata);
		assert (acked) else stop_with_error($sformatf("Register read of %h got no ack", addr));
		check_value(DATA_W'(expected), DATA_W'(rdata));
	endtask

	// Each word holds its own byte address and each burst starts every 64 bytes
	task automatic queue_transfer(input logic [ADDR_W-1:0] start, input int len);
		for (int i = 0; i < len / 8; i++) begin
			word_q.push_back(DATA_W'(start) + DATA_W'(8 * i));
			if (i % BURST_BEATS == 0)
				req_addr_q.push_back(start + ADDR_W'(8 * i));
		end
	endtask

	task automatic start_transfer(input logic [ADDR_W-1:0] start, input int len,
		input logic [CMD_W-1:0] mode);
		queue_transfer(start, len);
		write_reg(REG_NEXT_START, CSR_DATA_W'(start));
		write_reg(REG_NEXT_LEN, CSR_DATA_W'(len));
		write_reg(REG_COMMAND, CSR_DATA_W'(mode));
	endtask

	task automatic wait_transfer_done();
		while (word_q.size() != 0 || beat_q.size() != 0 || credits_owed != 0)
			@(negedge target_clk);
	endtask

	// Fabric responder and user drain share one random stream
	always @(posedge target_clk) begin
		fabric_rsp_valid <= 1'b0;
		fabric_credit    <= 1'b0;
		if (fabric_req_valid) begin
			assert (req_addr_q.size() != 0)
			else stop_with_error("Fabric request issued with no burst outstanding");
			check_value(DATA_W'(req_addr_q.pop_front()), DATA_W'(fabric_req_addr));
			for (int i = 0; i < BURST_BEATS; i++)
				beat_q.push_back(DATA_W'(fabric_req_addr) + DATA_W'(8 * i));
			req_count++;
		end
		if (foreign_on && rand_bit()) begin
			fabric_rsp_valid  <= 1'b1;
			fabric_rsp_data   <= '1;
			// Wrong device ID or wrong sub-device ID
			if (rand_bit()) begin
				fabric_rsp_did    <= FABRIC_DID;
				fabric_rsp_subdid <= ~FABRIC_SUBDID;
			end else begin
				fabric_rsp_did    <= ~FABRIC_DID;
				fabric_rsp_subdid <= FABRIC_SUBDID;
			end
		end else if (beat_q.size() != 0 && rand_bit()) begin
			fabric_rsp_valid  <= 1'b1;
			fabric_rsp_did    <= FABRIC_DID;
			fabric_rsp_subdid <= FABRIC_SUBDID;
			fabric_rsp_data   <= beat_q.pop_front();
			beats_sent++;
			if (beats_sent % BURST_BEATS == 0) begin
				credits_owed++;
				credit_wait = rand_bits(3);
			end
		end
		if (credit_wait != 0) begin
			credit_wait--;
		end else if (credits_owed != 0 && !hold_credits) begin
			fabric_credit <= 1'b1;
			credits_owed--;
			credit_wait = rand_bits(3);
		end
		user_request <= drain_on && rand_bit();
		if (user_data_ready) begin
			assert (word_q.size() != 0) else stop_with_error("User word delivered with none expected");
			check_value(word_q.pop_front(), user_data);
			words_seen++;
		end
	end

	always @(posedge target_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			stop_with_error($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin
		logic                  acked;
		logic [CSR_DATA_W-1:0] rdata;
		int                    base;
		int                    words_base;
		csr_valid = 1'b0;
		csr_r_nw  = 1'b0;
		csr_did   = '0;
		csr_addr  = '0;
		csr_wdata = '0;
		@(posedge target_rst_b);
		@(negedge target_clk);

		check_value(DATA_W'(1), DATA_W'(fifo_empty));
		check_value('0, DATA_W'({user_data_ready, fabric_req_valid, csr_ack}));
		read_reg(REG_BYTES_FETCHED, '0);
		read_reg(REG_BYTES_DELIVERED, '0);
		read_reg(REG_CURR_START, '0);
		// A trigger sent to another device must do nothing
		csr_access(1'b0, ~CSR_DID, REG_COMMAND, CSR_DATA_W'(DMA_TRIGGER_ONCE), acked, rdata);
		assert (!acked) else stop_with_error("Access with a foreign device ID was acknowledged");
		repeat (20) @(negedge target_clk);

		test_name = "one_shot";
		drain_on  = 1'b1;
		start_transfer(31'h1000, 256, DMA_TRIGGER_ONCE);
		wait_transfer_done();
		read_reg(REG_CURR_START, 32'h1000);
		read_reg(REG_BYTES_FETCHED, '0);
		repeat (40) @(negedge target_clk);

		test_name  = "foreign_ids";
		foreign_on = 1'b1;
		start_transfer(31'h2000, 128, DMA_TRIGGER_ONCE);
		wait_transfer_done();
		foreign_on = 1'b0;

		test_name    = "credit_stall";
		hold_credits = 1'b1;
		base         = req_count;
		start_transfer(31'h3000, 512, DMA_TRIGGER_ONCE);
		while (req_count < base + CREDITS_INIT)
			@(negedge target_clk);
		repeat (80) @(negedge target_clk);
		check_value(DATA_W'(base + CREDITS_INIT), DATA_W'(req_count));
		hold_credits = 1'b0;
		wait_transfer_done();

		test_name = "fifo_full";
		drain_on  = 1'b0;
		base      = req_count;
		start_transfer(31'h4000, 2048, DMA_TRIGGER_ONCE);
		while (req_count < base + FIFO_DEPTH / BURST_BEATS || beat_q.size() != 0)
			@(negedge target_clk);
		repeat (80) @(negedge target_clk);
		check_value(DATA_W'(base + FIFO_DEPTH / BURST_BEATS), DATA_W'(req_count));
		check_value(DATA_W'(0), DATA_W'(fifo_empty));
		words_base = words_seen;
		drain_on   = 1'b1;
		// Drain until every burst has landed and the FIFO is empty
		while (req_count < base + 2048 / BURST_BYTES || beat_q.size() != 0 ||
			fabric_rsp_valid || !fifo_empty)
			@(negedge target_clk);
		repeat (4) @(negedge target_clk);
		check_value(DATA_W'(2048 / 8), DATA_W'(words_seen - words_base));
		wait_transfer_done();

		test_name = "autotrigger";
		start_transfer(31'h5000, 256, DMA_AUTOTRIGGER);
		queue_transfer(31'h6000, 256);
		write_reg(REG_NEXT_START, 32'h6000);
		// Stop once the second transfer has begun
		while (req_addr_q.size() > 3)
			@(negedge target_clk);
		write_reg(REG_COMMAND, CSR_DATA_W'(DMA_STOP));
		wait_transfer_done();
		repeat (40) @(negedge target_clk);
		read_reg(REG_BYTES_DELIVERED, CSR_DATA_W'(8 * words_seen));

		$display("all tests passed");
		$finish;
	end

endmodule

/* tests/dma_read_controller_assertions.sv */
`timescale 1ns/1ps

module dma_read_controller_assertions import dma_read_pkg::*; (
	input logic                         target_clk,
	input logic                         target_rst_b,
	input logic                         fabric_req_valid,
	input logic [$clog2(BURST_BEATS):0] fabric_req_len,
	input logic [ID_W-1:0]              fabric_req_did,
	input logic [ID_W-1:0]              fabric_req_subdid,
	input logic                         fabric_credit,
	input logic                         fabric_rsp_valid,
	input logic [ID_W-1:0]              fabric_rsp_did,
	input logic [ID_W-1:0]              fabric_rsp_subdid,
	input logic                         user_request,
	input logic                         fifo_empty,
	input logic                         user_data_ready
);

	int   in_flight;
	int   stored;
	logic beat_hit;
	logic word_pop;

	assign beat_hit = fabric_rsp_valid &&
		(fabric_rsp_did == FABRIC_DID) && (fabric_rsp_subdid == FABRIC_SUBDID);
	assign word_pop = user_request && !fifo_empty;

	// Requests not yet paid back by a credit, and words held in the FIFO
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			in_flight <= 0;
			stored    <= 0;
		end else begin
			in_flight <= in_flight + int'(fabric_req_valid) - int'(fabric_credit);
			stored    <= stored + int'(beat_hit) - int'(word_pop);
		end
	end

	req_pulse_a: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		fabric_req_valid |=> !fabric_req_valid)
		else $error("fabric request held longer than one cycle");

	req_fields_a: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		fabric_req_valid |-> (fabric_req_len == BURST_BEATS) &&
			(fabric_req_did == FABRIC_DID) && (fabric_req_subdid == FABRIC_SUBDID))
		else $error("fabric request carries a wrong length or ID");

	credit_a: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		(in_flight >= CREDITS_INIT) |-> !fabric_req_valid)
		else $error("fabric request issued without a credit");

	// Request decided one cycle before the valid pulse
	room_a: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		fabric_req_valid |-> ($past(stored) <= FIFO_DEPTH - BURST_BEATS))
		else $error("fabric request issued without room for a burst");

	fill_a: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		(stored <= FIFO_DEPTH) && (fifo_empty == (stored == 0)))
		else $error("FIFO overflow or wrong empty flag");

	deliver_a: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		word_pop |=> user_data_ready)
		else $error("user request with data present got no word");

	idle_a: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		!word_pop |=> !user_data_ready)
		else $error("user data ready without a valid request");

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic target_clk,
	output logic target_rst_b
);

	localparam int RESET_CYCLES = 4;

	// 8 ns period
	initial begin
		target_clk = 1'b0;
		forever #4 target_clk = ~target_clk;
	end

	// Release on a falling edge away from the sampling edge
	initial begin
		target_rst_b = 1'b0;
		repeat (RESET_CYCLES) @(posedge target_clk);
		@(negedge target_clk);
		target_rst_b = 1'b1;
	end

endmodule

/* source/dma_read_controller.sv */
`timescale 1ns/1ps

module dma_read_controller import dma_read_pkg::*; (
	input  logic                         target_clk,
	input  logic                         target_rst_b,
	// Configuration port
	input  logic                         csr_valid,
	input  logic                         csr_r_nw,
	input  logic [ID_W-1:0]              csr_did,
	input  logic [CSR_ADDR_W-1:0]        csr_addr,
	input  csr_word_u                    csr_wdata,
	output logic                         csr_ack,
	output logic [CSR_DATA_W-1:0]        csr_rdata,
	// Fabric requests
	output logic                         fabric_req_valid,
	output logic [ADDR_W-1:0]            fabric_req_addr,
	output logic [$clog2(BURST_BEATS):0] fabric_req_len,
	output logic [ID_W-1:0]              fabric_req_did,
	output logic [ID_W-1:0]              fabric_req_subdid,
	input  logic                         fabric_credit,
	// Fabric responses
	input  logic                         fabric_rsp_valid,
	input  logic [ID_W-1:0]              fabric_rsp_did,
	input  logic [ID_W-1:0]              fabric_rsp_subdid,
	input  logic [DATA_W-1:0]            fabric_rsp_data,
	// User side
	input  logic                         user_request,
	output logic [DATA_W-1:0]            user_data,
	output logic                         user_data_ready,
	output logic                         fifo_empty
);

	logic [ADDR_W-1:0] next_start;
	logic [ADDR_W-1:0] next_len;
	logic [CMD_W-1:0]  command;
	logic              trigger_taken;
	logic [ADDR_W-1:0] bytes_fetched;
	logic [ADDR_W-1:0] curr_start;
	logic [ADDR_W-1:0] bytes_delivered;
	logic              burst_done;
	logic              fifo_has_room;

	dma_csr_regs i_dma_csr_regs (
		.target_clk      (target_clk),
		.target_rst_b    (target_rst_b),
		.csr_valid       (csr_valid),
		.csr_r_nw        (csr_r_nw),
		.csr_did         (csr_did),
		.csr_addr        (csr_addr),
		.csr_wdata       (csr_wdata),
		.trigger_taken   (trigger_taken),
		.bytes_fetched   (bytes_fetched),
		.curr_start      (curr_start),
		.bytes_delivered (bytes_delivered),
		.csr_ack         (csr_ack),
		.csr_rdata       (csr_rdata),
		.next_start      (next_start),
		.next_len        (next_len),
		.command         (command)
	);

	dma_fetch_sequencer i_dma_fetch_sequencer (
		.target_clk        (target_clk),
		.target_rst_b      (target_rst_b),
		.next_start        (next_start),
		.next_len          (next_len),
		.command           (command),
		.fabric_credit     (fabric_credit),
		.burst_done        (burst_done),
		.fifo_has_room     (fifo_has_room),
		.trigger_taken     (trigger_taken),
		.fabric_req_valid  (fabric_req_valid),
		.fabric_req_addr   (fabric_req_addr),
		.fabric_req_len    (fabric_req_len),
		.fabric_req_did    (fabric_req_did),
		.fabric_req_subdid (fabric_req_subdid),
		.bytes_fetched     (bytes_fetched),
		.curr_start        (curr_start)
	);

	dma_read_fifo i_dma_read_fifo (
		.target_clk        (target_clk),
		.target_rst_b      (target_rst_b),
		.fabric_rsp_valid  (fabric_rsp_valid),
		.fabric_rsp_did    (fabric_rsp_did),
		.fabric_rsp_subdid (fabric_rsp_subdid),
		.fabric_rsp_data   (fabric_rsp_data),
		.user_request      (user_request),
		.burst_done        (burst_done),
		.fifo_has_room     (fifo_has_room),
		.fifo_empty        (fifo_empty),
		.user_data         (user_data),
		.user_data_ready   (user_data_ready),
		.bytes_delivered   (bytes_delivered)
	);

endmodule

/* source/dma_read_fifo.sv */
`timescale 1ns/1ps

module dma_read_fifo import dma_read_pkg::*; (
	input  logic              target_clk,
	input  logic              target_rst_b,
	input  logic              fabric_rsp_valid,
	input  logic [ID_W-1:0]   fabric_rsp_did,
	input  logic [ID_W-1:0]   fabric_rsp_subdid,
	input  logic [DATA_W-1:0] fabric_rsp_data,
	input  logic              user_request,
	output logic              burst_done,
	output logic              fifo_has_room,
	output logic              fifo_empty,
	output logic [DATA_W-1:0] user_data,
	output logic              user_data_ready,
	output logic [ADDR_W-1:0] bytes_delivered
);

	logic [DATA_W-1:0]              mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0]             wr_ptr;
	logic [FIFO_AW-1:0]             rd_ptr;
	logic [FIFO_AW:0]               count;
	logic [$clog2(BURST_BEATS)-1:0] beat_cnt;
	logic                           rsp_hit;
	logic                           pop;

	// Only beats addressed to this engine
	assign rsp_hit = fabric_rsp_valid &&
		(fabric_rsp_did == FABRIC_DID) && (fabric_rsp_subdid == FABRIC_SUBDID);

	assign burst_done = rsp_hit && (beat_cnt == ($clog2(BURST_BEATS))'(BURST_BEATS - 1));

	assign fifo_empty = (count == '0);
	assign pop        = user_request && !fifo_empty;

	// Room for a whole burst must remain
	assign fifo_has_room = (count <= (FIFO_AW + 1)'(FIFO_DEPTH - BURST_BEATS));

	always_ff @(posedge target_clk) begin
		if (rsp_hit)
			mem[wr_ptr] <= fabric_rsp_data;
		if (pop)
			user_data <= mem[rd_ptr];
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			wr_ptr   <= '0;
			beat_cnt <= '0;
		end else if (rsp_hit) begin
			wr_ptr   <= wr_ptr + 1'b1;
			// Wraps back to zero after the last beat
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			rd_ptr          <= '0;
			user_data_ready <= 1'b0;
			bytes_delivered <= '0;
		end else begin
			user_data_ready <= pop;
			if (pop) begin
				rd_ptr          <= rd_ptr + 1'b1;
				bytes_delivered <= bytes_delivered + ADDR_W'(DATA_W / 8);
			end
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b)
			count <= '0;
		else if (rsp_hit && !pop)
			count <= count + 1'b1;
		else if (pop && !rsp_hit)
			count <= count - 1'b1;
	end

endmodule

/* source/dma_fetch_sequencer.sv */
`timescale 1ns/1ps

module dma_fetch_sequencer import dma_read_pkg::*; (
	input  logic                         target_clk,
	input  logic                         target_rst_b,
	input  logic [ADDR_W-1:0]            next_start,
	input  logic [ADDR_W-1:0]            next_len,
	input  logic [CMD_W-1:0]             command,
	input  logic                         fabric_credit,
	input  logic                         burst_done,
	input  logic                         fifo_has_room,
	output logic                         trigger_taken,
	output logic                         fabric_req_valid,
	output logic [ADDR_W-1:0]            fabric_req_addr,
	output logic [$clog2(BURST_BEATS):0] fabric_req_len,
	output logic [ID_W-1:0]              fabric_req_did,
	output logic [ID_W-1:0]              fabric_req_subdid,
	output logic [ADDR_W-1:0]            bytes_fetched,
	output logic [ADDR_W-1:0]            curr_start
);

	logic                active;
	logic                pending;
	logic [ADDR_W-1:0]   burst_addr;
	logic [ADDR_W-1:0]   end_addr;
	logic [CREDIT_W-1:0] credits;
	logic                issue;
	logic [ADDR_W-1:0]   issue_addr;
	logic                last_burst;

	// Idle engine picks up any run command
	assign trigger_taken = !active &&
		((command == DMA_TRIGGER_ONCE) || (command == DMA_AUTOTRIGGER));

	// First burst goes out on the same edge the transfer loads
	assign issue = (active || trigger_taken) && !pending && (credits != '0) && fifo_has_room;
	assign issue_addr = trigger_taken ? next_start : burst_addr;

	assign last_burst = ((burst_addr + ADDR_W'(BURST_BYTES)) == end_addr);

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			active        <= 1'b0;
			pending       <= 1'b0;
			burst_addr    <= '0;
			end_addr      <= '0;
			curr_start    <= '0;
			bytes_fetched <= '0;
		end else begin
			if (trigger_taken) begin
				active     <= 1'b1;
				burst_addr <= next_start;
				end_addr   <= next_start + next_len;
				curr_start <= next_start;
			end
			if (issue) begin
				pending <= 1'b1;
			end else if (pending && burst_done) begin
				pending <= 1'b0;
				if (last_burst) begin
					active        <= 1'b0;
					bytes_fetched <= '0;
				end else begin
					burst_addr    <= burst_addr + ADDR_W'(BURST_BYTES);
					bytes_fetched <= bytes_fetched + ADDR_W'(BURST_BYTES);
				end
			end
		end
	end

	// Credits return one at a time
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			credits <= CREDIT_W'(CREDITS_INIT);
		end else begin
			case ({fabric_credit, issue})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b)
			fabric_req_valid <= 1'b0;
		else
			fabric_req_valid <= issue;
	end

	// Request payload travels with the valid pulse
	always_ff @(posedge target_clk) begin
		if (issue) begin
			fabric_req_addr   <= issue_addr;
			fabric_req_len    <= ($clog2(BURST_BEATS) + 1)'(BURST_BEATS);
			fabric_req_did    <= FABRIC_DID;
			fabric_req_subdid <= FABRIC_SUBDID;
		end
	end

endmodule

/* source/dma_csr_regs.sv */
`timescale 1ns/1ps

module dma_csr_regs import dma_read_pkg::*; (
	input  logic                  target_clk,
	input  logic                  target_rst_b,
	input  logic                  csr_valid,
	input  logic                  csr_r_nw,
	input  logic [ID_W-1:0]       csr_did,
	input  logic [CSR_ADDR_W-1:0] csr_addr,
	input  csr_word_u             csr_wdata,
	input  logic                  trigger_taken,
	input  logic [ADDR_W-1:0]     bytes_fetched,
	input  logic [ADDR_W-1:0]     curr_start,
	input  logic [ADDR_W-1:0]     bytes_delivered,
	output logic                  csr_ack,
	output logic [CSR_DATA_W-1:0] csr_rdata,
	output logic [ADDR_W-1:0]     next_start,
	output logic [ADDR_W-1:0]     next_len,
	output logic [CMD_W-1:0]      command
);

	logic dev_sel;
	logic wr_start;
	logic wr_len;
	logic wr_cmd;
	logic rd_hit;
	logic [ADDR_W-1:0] rd_value;

	assign dev_sel = csr_valid && (csr_did == CSR_DID);

	// Write decode
	assign wr_start = dev_sel && !csr_r_nw && (csr_addr == REG_NEXT_START);
	assign wr_len   = dev_sel && !csr_r_nw && (csr_addr == REG_NEXT_LEN);
	assign wr_cmd   = dev_sel && !csr_r_nw && (csr_addr == REG_COMMAND);

	// Read decode and status select
	always_comb begin
		rd_hit   = 1'b0;
		rd_value = '0;
		if (dev_sel && csr_r_nw) begin
			case (csr_addr)
				REG_BYTES_FETCHED: begin
					rd_hit   = 1'b1;
					rd_value = bytes_fetched;
				end
				REG_BYTES_DELIVERED: begin
					rd_hit   = 1'b1;
					rd_value = bytes_delivered;
				end
				REG_CURR_START: begin
					rd_hit   = 1'b1;
					rd_value = curr_start;
				end
				default: begin
					rd_hit   = 1'b0;
					rd_value = '0;
				end
			endcase
		end
	end

	// Ack and readback one cycle after the access
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			csr_ack   <= 1'b0;
			csr_rdata <= '0;
		end else begin
			csr_ack   <= wr_start || wr_len || wr_cmd || rd_hit;
			csr_rdata <= {{(CSR_DATA_W-ADDR_W){1'b0}}, rd_value};
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			next_start <= '0;
			next_len   <= '0;
		end else begin
			if (wr_start)
				next_start <= csr_wdata.value[ADDR_W-1:0];
			if (wr_len)
				next_len <= csr_wdata.value[ADDR_W-1:0];
		end
	end

	// A fresh command write beats the one-shot clear
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			command <= DMA_STOP;
		end else if (wr_cmd) begin
			command <= csr_wdata.cmd.mode;
		end else if (trigger_taken && (command == DMA_TRIGGER_ONCE)) begin
			command <= DMA_STOP;
		end
	end

endmodule

/* source/dma_read_pkg.sv */
package dma_read_pkg;

	// Bus widths
	localparam int ADDR_W     = 31;
	localparam int DATA_W     = 64;
	localparam int CSR_DATA_W = 32;
	localparam int CSR_ADDR_W = 5;
	localparam int ID_W       = 4;

	// Device IDs on the fabric and on the configuration port
	localparam logic [ID_W-1:0] FABRIC_DID    = 4'd3;
	localparam logic [ID_W-1:0] FABRIC_SUBDID = 4'd5;
	localparam logic [ID_W-1:0] CSR_DID       = 4'd2;

	// One burst is a 64-byte line
	localparam int BURST_BEATS = 8;
	localparam int BURST_BYTES = 64;

	localparam int FIFO_DEPTH = 128;
	localparam int FIFO_AW    = 7;

	localparam int CREDITS_INIT = 4;
	localparam int CREDIT_W     = 3;

	// Command codes
	localparam int CMD_W = 2;
	localparam logic [CMD_W-1:0] DMA_STOP         = 2'd0;
	localparam logic [CMD_W-1:0] DMA_TRIGGER_ONCE = 2'd1;
	localparam logic [CMD_W-1:0] DMA_AUTOTRIGGER  = 2'd2;

	// Register map
	localparam logic [CSR_ADDR_W-1:0] REG_NEXT_START      = 5'h00;
	localparam logic [CSR_ADDR_W-1:0] REG_NEXT_LEN        = 5'h04;
	localparam logic [CSR_ADDR_W-1:0] REG_COMMAND         = 5'h08;
	localparam logic [CSR_ADDR_W-1:0] REG_BYTES_FETCHED   = 5'h0C;
	localparam logic [CSR_ADDR_W-1:0] REG_BYTES_DELIVERED = 5'h10;
	localparam logic [CSR_ADDR_W-1:0] REG_CURR_START      = 5'h14;

	// Configuration write word as a plain value or as a command
	typedef union packed {
		logic [CSR_DATA_W-1:0] value;
		struct packed {
			logic [CSR_DATA_W-CMD_W-1:0] unused;
			logic [CMD_W-1:0]            mode;
		} cmd;
	} csr_word_u;

endpackage
